//--- verilog/snowball_pkg.sv
`default_nettype none

package snowball_pkg;

  // ------------------------------------------------------------
  // Widths and sizes
  // ------------------------------------------------------------
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int IDX_W     = 8;                // Cache and TLB index
  localparam int CTAG_W    = ADDR_W - IDX_W;   // Physical address 31:8
  localparam int PAGE_W    = 16;               // Address 31:16
  localparam int NUM_LINES = 1 << IDX_W;       // Lines and TLB entries

  // ------------------------------------------------------------
  // Request structs
  // ------------------------------------------------------------
  // Lookup request after translation
  typedef struct packed {
    logic              valid;
    logic              we;
    logic              force_miss;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] wdata;
  } xlat_req_t;

  // One word transfer on memory or DMA
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // ------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------
  typedef enum logic {
    REG_MEM,                                   // Address 31:30 is 00, 01 or 10
    REG_DMA                                    // Address 31:30 is 11
  } region_t;

  typedef enum logic [1:0] {
    CS_IDLE,
    CS_BUS,                                    // Waiting for bus_done
    CS_FILL                                    // Line write
  } ctrl_state_t;

  typedef enum logic [1:0] {
    BS_IDLE,
    BS_MEM,
    BS_DMA
  } bus_state_t;

endpackage

`default_nettype wire

//--- verilog/cache_array.sv
`timescale 1ns/100ps
`default_nettype none

module cache_array (
  input  wire logic                            CPU_CLK,
  input  wire logic                            RST,
  input  wire logic [snowball_pkg::IDX_W-1:0]  rd_idx,
  input  wire logic                            rd_en,
  output logic                                 rd_valid,
  output logic [snowball_pkg::CTAG_W-1:0]      rd_tag,
  output logic [snowball_pkg::DATA_W-1:0]      rd_data,
  input  wire logic                            wr_en,
  input  wire logic [snowball_pkg::IDX_W-1:0]  wr_idx,
  input  wire logic [snowball_pkg::CTAG_W-1:0] wr_tag,
  input  wire logic [snowball_pkg::DATA_W-1:0] wr_data
);
  import snowball_pkg::*;

  logic [NUM_LINES-1:0] valid_q;
  logic [CTAG_W-1:0]    tag_mem  [NUM_LINES];
  logic [DATA_W-1:0]    data_mem [NUM_LINES];
  logic                 wr_hit_rd;

  // A read on the edge of a line write sees the new line
  assign wr_hit_rd = wr_en && (wr_idx == rd_idx);

  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
        valid_q[wr_idx] <= 1'b1;
      if (rd_en)
        rd_valid <= valid_q[rd_idx] || wr_hit_rd;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx]  <= wr_tag;
      data_mem[wr_idx] <= wr_data;
    end
    if (rd_en)
    begin
      rd_tag  <= wr_hit_rd ? wr_tag : tag_mem[rd_idx];
      rd_data <= wr_hit_rd ? wr_data : data_mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- verilog/tlb_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_unit (
  input  wire logic                            CPU_CLK,
  input  wire logic                            RST,
  input  wire logic                            cache_precycle_enable,
  input  wire logic                            cache_precycle_we,
  input  wire logic                            cache_precycle_force_miss,
  input  wire logic                            WE_TLB,
  input  wire logic                            VMEM_ACT,
  input  wire logic [snowball_pkg::ADDR_W-1:0] cache_precycle_addr,
  input  wire logic [snowball_pkg::DATA_W-1:0] cache_datao,
  input  wire logic                            ctrl_busy,
  output logic                                 rd_en_pre,
  output logic [snowball_pkg::IDX_W-1:0]       idx_pre,
  output snowball_pkg::xlat_req_t              req,
  output logic                                 fault
);
  import snowball_pkg::*;

  logic [PAGE_W-1:0] tlb_ppage [NUM_LINES];
  logic [PAGE_W-1:0] tlb_vpage [NUM_LINES];
  logic [PAGE_W-1:0] rd_ppage;
  logic [PAGE_W-1:0] rd_vpage;
  logic [IDX_W-1:0]  tlb_idx;
  logic              idle;
  logic              tlb_we;
  logic              page_miss;
  logic              s1_valid;
  logic              s1_we;
  logic              s1_force_miss;
  logic              s1_vmem;
  logic [ADDR_W-1:0] s1_addr;
  logic [DATA_W-1:0] s1_wdata;

  // One request in flight, so nothing is taken while the lookup runs
  assign idle      = !ctrl_busy && !s1_valid && !req.valid;
  assign rd_en_pre = cache_precycle_enable && idle;
  assign tlb_we    = WE_TLB && idle;
  assign idx_pre   = cache_precycle_addr[IDX_W-1:0];
  assign tlb_idx   = cache_precycle_addr[2*IDX_W-1:IDX_W];            // Bits 15:8
  assign page_miss = s1_vmem && (rd_vpage != s1_addr[ADDR_W-1:ADDR_W-PAGE_W]);

  // ------------------------------------------------------------
  // TLB storage, physical page in 31:16 and virtual page in 15:0
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (tlb_we)
    begin
      tlb_ppage[tlb_idx] <= cache_datao[DATA_W-1:DATA_W-PAGE_W];
      tlb_vpage[tlb_idx] <= cache_datao[PAGE_W-1:0];
    end
    if (rd_en_pre)
    begin
      rd_ppage <= tlb_ppage[tlb_idx];                                 // Ready at E
      rd_vpage <= tlb_vpage[tlb_idx];
    end
  end

  // ------------------------------------------------------------
  // Capture at E, translate into req at E+1
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      s1_valid  <= 1'b0;
      req.valid <= 1'b0;
      fault     <= 1'b0;
    end
    else
    begin
      s1_valid  <= rd_en_pre;
      req.valid <= s1_valid && !page_miss;                            // Dropped on fault
      fault     <= s1_valid && page_miss;
    end
    if (rd_en_pre)
    begin
      s1_we         <= cache_precycle_we;
      s1_force_miss <= cache_precycle_force_miss;
      s1_vmem       <= VMEM_ACT;
      s1_addr       <= cache_precycle_addr;
      s1_wdata      <= cache_datao;
    end
    req.we         <= s1_we;
    req.force_miss <= s1_force_miss;
    req.paddr      <= s1_vmem ? {rd_ppage, s1_addr[ADDR_W-PAGE_W-1:0]} : s1_addr;
    req.wdata      <= s1_wdata;
  end

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  wire logic                            CPU_CLK,
  input  wire logic                            RST,
  input  wire snowball_pkg::xlat_req_t         req,
  input  wire logic                            fault,
  input  wire logic                            rd_en_pre,
  input  wire logic [snowball_pkg::IDX_W-1:0]  idx_pre,
  input  wire logic                            bus_done,
  input  wire logic [snowball_pkg::DATA_W-1:0] bus_rdata,
  output logic                                 bus_start,
  output snowball_pkg::bus_req_t               bus_cmd,
  output logic [snowball_pkg::DATA_W-1:0]      cache_datai,
  output logic                                 cache_busy,
  output logic                                 MMU_FAULT
);
  import snowball_pkg::*;

  ctrl_state_t       state;
  logic              rd_valid;
  logic [CTAG_W-1:0] rd_tag;
  logic [DATA_W-1:0] rd_data;
  logic              wr_en;
  logic [DATA_W-1:0] wr_data;
  logic              lookup;
  logic              hit;
  logic              read_hit;
  logic              take_bus;
  logic              bus_back;

  // ------------------------------------------------------------
  // Line storage
  // ------------------------------------------------------------
  cache_array cache_array_i (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .rd_idx  (idx_pre),                                    // Read at E, held until next request
    .rd_en   (rd_en_pre),
    .rd_valid(rd_valid),
    .rd_tag  (rd_tag),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_idx  (bus_cmd.addr[IDX_W-1:0]),
    .wr_tag  (bus_cmd.addr[ADDR_W-1:IDX_W]),
    .wr_data (wr_data)
  );

  // ------------------------------------------------------------
  // Hit compare
  // ------------------------------------------------------------
  assign lookup   = (state == CS_IDLE) && req.valid;
  assign hit      = rd_valid && (rd_tag == req.paddr[ADDR_W-1:IDX_W]) && !req.force_miss;
  assign read_hit = lookup && !req.we && hit;
  assign take_bus = lookup && !read_hit;                   // Miss, write or forced miss
  assign bus_back = (state == CS_BUS) && bus_done;

  // Write-allocate keeps the stored word, a read fill keeps the returned one
  assign wr_en   = (state == CS_FILL);
  assign wr_data = bus_cmd.we ? bus_cmd.wdata : cache_datai;

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      state      <= CS_IDLE;
      cache_busy <= 1'b0;
      bus_start  <= 1'b0;
      MMU_FAULT  <= 1'b0;
    end
    else
    begin
      bus_start <= take_bus;                               // Single cycle pulse
      MMU_FAULT <= fault;
      case (state)
        CS_IDLE:
        begin
          if (take_bus)
          begin
            state      <= CS_BUS;
            cache_busy <= 1'b1;
          end
        end
        CS_BUS:
        begin
          if (bus_done)
          begin
            state      <= CS_FILL;
            cache_busy <= 1'b0;                            // Drops with the data
          end
        end
        CS_FILL:
          state <= CS_IDLE;
        default:
          state <= CS_IDLE;
      endcase
    end
  end

  // Bus command stays put until the line is written
  always_ff @(posedge CPU_CLK)
  begin
    if (take_bus)
    begin
      bus_cmd.we    <= req.we;
      bus_cmd.addr  <= req.paddr;
      bus_cmd.wdata <= req.wdata;
    end
    if (read_hit)
      cache_datai <= rd_data;
    else if (bus_back && !bus_cmd.we)
      cache_datai <= bus_rdata;
  end

endmodule

`default_nettype wire

//--- verilog/bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module bus_master (
  input  wire logic                            CPU_CLK,
  input  wire logic                            RST,
  input  wire logic                            bus_start,
  input  wire snowball_pkg::bus_req_t          bus_cmd,
  output logic                                 bus_done,
  output logic [snowball_pkg::DATA_W-1:0]      bus_rdata,
  output logic [snowball_pkg::ADDR_W-1:0]      mem_addr,
  output logic                                 mem_we,
  output logic                                 mem_do_act,
  output logic [snowball_pkg::DATA_W-1:0]      mem_dataintomem,
  input  wire logic                            mem_ack,
  input  wire logic [snowball_pkg::DATA_W-1:0] mem_datafrommem,
  output logic                                 dma_wrte,
  output logic                                 dma_read,
  input  wire logic                            dma_wrte_ack,
  input  wire logic                            dma_read_ack,
  input  wire logic [snowball_pkg::DATA_W-1:0] dma_data_read
);
  import snowball_pkg::*;

  bus_state_t state;
  region_t    region;
  logic       launch;
  logic       mem_fin;
  logic       dma_fin;

  assign region  = (bus_cmd.addr[ADDR_W-1:ADDR_W-2] == 2'b11) ? REG_DMA : REG_MEM;
  assign launch  = bus_start && (state == BS_IDLE);
  assign mem_fin = (state == BS_MEM) && mem_ack;
  assign dma_fin = (state == BS_DMA) &&
                   ((dma_read && dma_read_ack) || (dma_wrte && dma_wrte_ack));

  // ------------------------------------------------------------
  // Act levels held until the ack
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      state      <= BS_IDLE;
      mem_do_act <= 1'b0;
      mem_we     <= 1'b0;
      dma_read   <= 1'b0;
      dma_wrte   <= 1'b0;
      bus_done   <= 1'b0;
    end
    else
    begin
      bus_done <= mem_fin || dma_fin;
      case (state)
        BS_IDLE:
        begin
          if (launch && (region == REG_DMA))
          begin
            state    <= BS_DMA;
            dma_read <= !bus_cmd.we;
            dma_wrte <= bus_cmd.we;
          end
          else if (launch)
          begin
            state      <= BS_MEM;
            mem_do_act <= 1'b1;
            mem_we     <= bus_cmd.we;
          end
        end
        BS_MEM:
        begin
          if (mem_ack)
          begin
            state      <= BS_IDLE;
            mem_do_act <= 1'b0;
            mem_we     <= 1'b0;
          end
        end
        BS_DMA:
        begin
          if (dma_fin)
          begin
            state    <= BS_IDLE;
            dma_read <= 1'b0;
            dma_wrte <= 1'b0;
          end
        end
        default:
          state <= BS_IDLE;
      endcase
    end
  end

  // Address and write data shared by both targets
  always_ff @(posedge CPU_CLK)
  begin
    if (launch)
    begin
      mem_addr        <= bus_cmd.addr;
      mem_dataintomem <= bus_cmd.wdata;
    end
    if (mem_fin)
      bus_rdata <= mem_datafrommem;                        // Taken in the ack cycle
    else if (dma_fin)
      bus_rdata <= dma_data_read;
  end

endmodule

`default_nettype wire

//--- verilog/snowball_cache.sv
`timescale 1ns/100ps
`default_nettype none

module snowball_cache (
  input  wire logic                            CPU_CLK,
  input  wire logic                            RST,
  // ------------------------------------------------------------
  input  wire logic [snowball_pkg::ADDR_W-1:0] cache_precycle_addr,
  input  wire logic [snowball_pkg::DATA_W-1:0] cache_datao,      // Write data from CPU
  output logic [snowball_pkg::DATA_W-1:0]      cache_datai,      // Read data to CPU
  input  wire logic                            cache_precycle_we,
  output logic                                 cache_busy,
  input  wire logic                            cache_precycle_enable,
  input  wire logic                            cache_precycle_force_miss,
  // ------------------------------------------------------------
  output logic [snowball_pkg::ADDR_W-1:0]      mem_addr,
  output logic                                 mem_we,
  output logic                                 mem_do_act,
  output logic [snowball_pkg::DATA_W-1:0]      mem_dataintomem,
  input  wire logic                            mem_ack,
  input  wire logic [snowball_pkg::DATA_W-1:0] mem_datafrommem,
  // ------------------------------------------------------------
  output logic                                 dma_wrte,
  output logic                                 dma_read,
  input  wire logic                            dma_wrte_ack,
  input  wire logic                            dma_read_ack,
  input  wire logic [snowball_pkg::DATA_W-1:0] dma_data_read,
  // ------------------------------------------------------------
  input  wire logic                            VMEM_ACT,
  output logic                                 MMU_FAULT,
  input  wire logic                            WE_TLB
);
  import snowball_pkg::*;

  xlat_req_t         req;
  bus_req_t          bus_cmd;
  logic              fault;
  logic              rd_en_pre;
  logic [IDX_W-1:0]  idx_pre;
  logic              bus_start;
  logic              bus_done;
  logic [DATA_W-1:0] bus_rdata;

  tlb_unit tlb_unit_i (
    .CPU_CLK                  (CPU_CLK),
    .RST                      (RST),
    .cache_precycle_enable    (cache_precycle_enable),
    .cache_precycle_we        (cache_precycle_we),
    .cache_precycle_force_miss(cache_precycle_force_miss),
    .WE_TLB                   (WE_TLB),
    .VMEM_ACT                 (VMEM_ACT),
    .cache_precycle_addr      (cache_precycle_addr),
    .cache_datao              (cache_datao),
    .ctrl_busy                (cache_busy),
    .rd_en_pre                (rd_en_pre),
    .idx_pre                  (idx_pre),
    .req                      (req),
    .fault                    (fault)
  );

  cache_ctrl cache_ctrl_i (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .req        (req),
    .fault      (fault),
    .rd_en_pre  (rd_en_pre),
    .idx_pre    (idx_pre),
    .bus_done   (bus_done),
    .bus_rdata  (bus_rdata),
    .bus_start  (bus_start),
    .bus_cmd    (bus_cmd),
    .cache_datai(cache_datai),
    .cache_busy (cache_busy),
    .MMU_FAULT  (MMU_FAULT)
  );

  bus_master bus_master_i (
    .CPU_CLK        (CPU_CLK),
    .RST            (RST),
    .bus_start      (bus_start),
    .bus_cmd        (bus_cmd),
    .bus_done       (bus_done),
    .bus_rdata      (bus_rdata),
    .mem_addr       (mem_addr),
    .mem_we         (mem_we),
    .mem_do_act     (mem_do_act),
    .mem_dataintomem(mem_dataintomem),
    .mem_ack        (mem_ack),
    .mem_datafrommem(mem_datafrommem),
    .dma_wrte       (dma_wrte),
    .dma_read       (dma_read),
    .dma_wrte_ack   (dma_wrte_ack),
    .dma_read_ack   (dma_read_ack),
    .dma_data_read  (dma_data_read)
  );

endmodule

`default_nettype wire

//--- tests/snowball_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module snowball_mem_model (
  input  wire logic                            CPU_CLK,
  input  wire logic                            RST,
  input  wire logic [snowball_pkg::ADDR_W-1:0] mem_addr,
  input  wire logic                            mem_we,
  input  wire logic                            mem_do_act,
  input  wire logic [snowball_pkg::DATA_W-1:0] mem_dataintomem,
  output logic                                 mem_ack,
  output logic [snowball_pkg::DATA_W-1:0]      mem_datafrommem,
  input  wire logic                            dma_wrte,
  input  wire logic                            dma_read,
  output logic                                 dma_wrte_ack,
  output logic                                 dma_read_ack,
  output logic [snowball_pkg::DATA_W-1:0]      dma_data_read,
  output int                                   mem_count,
  output int                                   dma_count,
  output logic [snowball_pkg::ADDR_W-1:0]      last_wr_addr,
  output logic [snowball_pkg::DATA_W-1:0]      last_wr_data
);
  import snowball_pkg::*;

  logic [DATA_W-1:0] store [logic [ADDR_W-1:0]];         // Only written words
  logic              pending;
  int unsigned       delay;

  // Unwritten words hold their address XOR 32'h5A5A_0000
  function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
    if (store.exists(addr))
      return store[addr];
    return addr ^ 32'h5A5A_0000;
  endfunction

  // Both ports share the address and write data lines
  task automatic serve_access();
    logic is_dma;
    is_dma = dma_read || dma_wrte;
    if (mem_we || dma_wrte)
    begin
      store[mem_addr] = mem_dataintomem;
      last_wr_addr    = mem_addr;
      last_wr_data    = mem_dataintomem;
    end
    if (is_dma)
    begin
      dma_count     = dma_count + 1;
      dma_data_read = read_word(mem_addr);
      dma_read_ack  = dma_read;
      dma_wrte_ack  = dma_wrte;
    end
    else
    begin
      mem_count       = mem_count + 1;
      mem_datafrommem = read_word(mem_addr);
      mem_ack         = 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // Ack engine, one access at a time, outputs move on falling edges
  // ------------------------------------------------------------
  initial
  begin
    void'($urandom(11565));                              // Seeds the ack delays
    pending         = 1'b0;
    delay           = 0;
    mem_ack         = 1'b0;
    dma_wrte_ack    = 1'b0;
    dma_read_ack    = 1'b0;
    mem_datafrommem = '0;
    dma_data_read   = '0;
    mem_count       = 0;
    dma_count       = 0;
    last_wr_addr    = '0;
    last_wr_data    = '0;
    forever
    begin
      @(negedge CPU_CLK);
      if (RST || mem_ack || dma_read_ack || dma_wrte_ack)
      begin
        mem_ack      = 1'b0;                             // Ack lasts one cycle
        dma_read_ack = 1'b0;
        dma_wrte_ack = 1'b0;
        pending      = 1'b0;
      end
      else if (pending)
      begin
        if (delay > 1)
          delay = delay - 1;
        else
          serve_access();
      end
      else if (mem_do_act || dma_read || dma_wrte)
      begin
        pending = 1'b1;
        delay   = $urandom_range(4, 1);                  // 1 to 4 cycles
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_snowball_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_snowball_cache;
  import snowball_pkg::*;

  // About 15 accesses of at most 15 cycles each, plus reset, with wide margin
  localparam int CYCLE_LIMIT = 2000;
  localparam int BUSY_LIMIT  = 40;                       // Worst bus cycle is far shorter

  localparam logic [ADDR_W-1:0] ADDR_A   = 32'h0000_1234;
  localparam logic [ADDR_W-1:0] ADDR_B   = 32'h0000_2240;
  localparam logic [DATA_W-1:0] DATA_B   = 32'hCAFE_0001;
  localparam logic [ADDR_W-1:0] ADDR_C1  = 32'h0001_0050; // Same index as ADDR_C2
  localparam logic [ADDR_W-1:0] ADDR_C2  = 32'h0002_0050;
  localparam logic [ADDR_W-1:0] VADDR    = 32'h0040_0710; // TLB index 8'h07
  localparam logic [PAGE_W-1:0] PPAGE    = 16'h0123;
  localparam logic [ADDR_W-1:0] BAD_VA   = 32'h0050_0710; // Same entry, other page
  localparam logic [ADDR_W-1:0] DMA_RD   = 32'hC000_0120;
  localparam logic [ADDR_W-1:0] DMA_WR   = 32'hC000_0238;
  localparam logic [DATA_W-1:0] DMA_DATA = 32'h1357_9BDF;
  localparam logic [ADDR_W-1:0] MEM_HI   = 32'h8000_0300; // Bits 31:30 are 10

  logic              CPU_CLK;
  logic              RST;
  logic [ADDR_W-1:0] cache_precycle_addr;
  logic [DATA_W-1:0] cache_datao;
  logic [DATA_W-1:0] cache_datai;
  logic              cache_precycle_we;
  logic              cache_busy;
  logic              cache_precycle_enable;
  logic              cache_precycle_force_miss;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  logic              mem_do_act;
  logic [DATA_W-1:0] mem_dataintomem;
  logic              mem_ack;
  logic [DATA_W-1:0] mem_datafrommem;
  logic              dma_wrte;
  logic              dma_read;
  logic              dma_wrte_ack;
  logic              dma_read_ack;
  logic [DATA_W-1:0] dma_data_read;
  logic              VMEM_ACT;
  logic              MMU_FAULT;
  logic              WE_TLB;
  int                mem_count;
  int                dma_count;
  logic [ADDR_W-1:0] last_wr_addr;
  logic [DATA_W-1:0] last_wr_data;
  int                errors;
  int                tests_run;
  int                cycle_count;

  snowball_cache snowball_cache_i (.*);
  snowball_mem_model mem_model_i (.*);

  always
  begin
    CPU_CLK = 1'b0;
    #10;
    CPU_CLK = 1'b1;
    #10;
  end

  always @(posedge CPU_CLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles with tests still running", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] addr);
    return addr ^ 32'h5A5A_0000;                         // Model fill pattern
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic expect_counts(input int exp_mem, input int exp_dma);
    if (mem_count != exp_mem || dma_count != exp_dma)
      report_mismatch($sformatf("accesses mem %0d dma %0d, expected mem %0d dma %0d",
                                mem_count, dma_count, exp_mem, exp_dma));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    $display("Test %s done, %0d errors", name, errors - errs_before);
  endtask

  // One CPU request, sampled at edge E, results read on falling edges
  task automatic cpu_access(
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              force_miss,
    output logic [DATA_W-1:0] rdata,
    output logic              missed,
    output logic              faulted
  );
    int waited;
    waited = 0;
    @(negedge CPU_CLK);
    cache_precycle_enable     = 1'b1;
    cache_precycle_we         = we;
    cache_precycle_addr       = addr;
    cache_datao               = wdata;
    cache_precycle_force_miss = force_miss;
    @(negedge CPU_CLK);                                  // Edge E passed
    cache_precycle_enable     = 1'b0;
    cache_precycle_we         = 1'b0;
    cache_precycle_force_miss = 1'b0;
    repeat (2) @(negedge CPU_CLK);                       // E+2 passed
    missed  = cache_busy;
    faulted = MMU_FAULT;
    while (cache_busy && waited < BUSY_LIMIT)
    begin
      @(negedge CPU_CLK);
      waited++;
    end
    if (cache_busy)
    begin
      $display("cache_busy stayed high for %0d cycles after a request to %h", BUSY_LIMIT, addr);
      errors++;
    end
    rdata = cache_datai;
    @(negedge CPU_CLK);
    if (MMU_FAULT)
      report_mismatch("MMU_FAULT high for more than one cycle");
  endtask

  task automatic tlb_write(input logic [ADDR_W-1:0] vaddr, input logic [PAGE_W-1:0] ppage);
    @(negedge CPU_CLK);
    WE_TLB              = 1'b1;
    cache_precycle_addr = vaddr;
    cache_datao         = {ppage, vaddr[ADDR_W-1:ADDR_W-PAGE_W]}; // Physical, then virtual
    @(negedge CPU_CLK);
    WE_TLB              = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic read_miss_then_hit();
    int                errs;
    int                mem0;
    int                dma0;
    logic [DATA_W-1:0] rd;
    logic              missed;
    logic              faulted;
    errs = errors;
    mem0 = mem_count;
    dma0 = dma_count;
    cpu_access(1'b0, ADDR_A, '0, 1'b0, rd, missed, faulted);
    if (!missed)
      report_mismatch("first read did not raise cache_busy");
    compare_word("miss data", rd, initial_word(ADDR_A));
    expect_counts(mem0 + 1, dma0);
    cpu_access(1'b0, ADDR_A, '0, 1'b0, rd, missed, faulted);
    if (missed)
      report_mismatch("second read raised cache_busy");
    compare_word("hit data", rd, initial_word(ADDR_A));
    expect_counts(mem0 + 1, dma0);
    finish_test("read_miss_hit", errs);
  endtask

  task automatic write_through_hit();
    int                errs;
    int                mem0;
    int                dma0;
    logic [DATA_W-1:0] rd;
    logic              missed;
    logic              faulted;
    errs = errors;
    mem0 = mem_count;
    dma0 = dma_count;
    cpu_access(1'b1, ADDR_B, DATA_B, 1'b0, rd, missed, faulted);
    if (!missed)
      report_mismatch("write did not raise cache_busy");
    expect_counts(mem0 + 1, dma0);
    compare_word("memory write address", last_wr_addr, ADDR_B);
    compare_word("memory write data", last_wr_data, DATA_B);
    cpu_access(1'b0, ADDR_B, '0, 1'b0, rd, missed, faulted);
    if (missed)
      report_mismatch("read after write missed");
    compare_word("read after write", rd, DATA_B);
    expect_counts(mem0 + 1, dma0);
    finish_test("write_through", errs);
  endtask

  task automatic conflict_eviction();
    int                errs;
    int                mem0;
    int                dma0;
    logic [DATA_W-1:0] rd;
    logic              missed;
    logic              faulted;
    errs = errors;
    mem0 = mem_count;
    dma0 = dma_count;
    cpu_access(1'b0, ADDR_C1, '0, 1'b0, rd, missed, faulted);
    compare_word("first line data", rd, initial_word(ADDR_C1));
    cpu_access(1'b0, ADDR_C2, '0, 1'b0, rd, missed, faulted);
    if (!missed)
      report_mismatch("conflicting address hit");
    compare_word("second line data", rd, initial_word(ADDR_C2));
    cpu_access(1'b0, ADDR_C1, '0, 1'b0, rd, missed, faulted);
    if (!missed)
      report_mismatch("evicted line still hit");
    compare_word("refetched data", rd, initial_word(ADDR_C1));
    expect_counts(mem0 + 3, dma0);
    finish_test("conflict", errs);
  endtask

  task automatic forced_miss_refetch();
    int                errs;
    int                mem0;
    int                dma0;
    logic [DATA_W-1:0] rd;
    logic              missed;
    logic              faulted;
    errs = errors;
    mem0 = mem_count;
    dma0 = dma_count;
    cpu_access(1'b0, ADDR_A, '0, 1'b1, rd, missed, faulted);
    if (!missed)
      report_mismatch("forced read of a cached line did not raise cache_busy");
    compare_word("forced read data", rd, initial_word(ADDR_A));
    cpu_access(1'b0, ADDR_B, '0, 1'b1, rd, missed, faulted);
    compare_word("forced read of written word", rd, DATA_B);
    expect_counts(mem0 + 2, dma0);
    finish_test("force_miss", errs);
  endtask

  task automatic page_translation();
    int                errs;
    int                mem0;
    int                dma0;
    logic [DATA_W-1:0] rd;
    logic              missed;
    logic              faulted;
    errs = errors;
    mem0 = mem_count;
    dma0 = dma_count;
    tlb_write(VADDR, PPAGE);
    VMEM_ACT = 1'b1;
    cpu_access(1'b0, VADDR, '0, 1'b0, rd, missed, faulted);
    if (faulted)
      report_mismatch("fault on a matching page");
    compare_word("translated data", rd, initial_word({PPAGE, VADDR[15:0]}));
    expect_counts(mem0 + 1, dma0);
    cpu_access(1'b0, BAD_VA, '0, 1'b0, rd, missed, faulted);
    if (!faulted)
      report_mismatch("no MMU_FAULT on a page mismatch");
    if (missed)
      report_mismatch("cache_busy rose on a faulted request");
    expect_counts(mem0 + 1, dma0);
    VMEM_ACT = 1'b0;
    finish_test("translation", errs);
  endtask

  task automatic dma_region_split();
    int                errs;
    int                mem0;
    int                dma0;
    logic [DATA_W-1:0] rd;
    logic              missed;
    logic              faulted;
    errs = errors;
    mem0 = mem_count;
    dma0 = dma_count;
    cpu_access(1'b0, DMA_RD, '0, 1'b0, rd, missed, faulted);
    compare_word("DMA read data", rd, initial_word(DMA_RD));
    expect_counts(mem0, dma0 + 1);
    cpu_access(1'b1, DMA_WR, DMA_DATA, 1'b0, rd, missed, faulted);
    expect_counts(mem0, dma0 + 2);
    compare_word("DMA write address", last_wr_addr, DMA_WR);
    compare_word("DMA write data", last_wr_data, DMA_DATA);
    cpu_access(1'b0, DMA_WR, '0, 1'b1, rd, missed, faulted);
    compare_word("DMA read back", rd, DMA_DATA);
    expect_counts(mem0, dma0 + 3);
    // Top of the memory region, next to the DMA region
    cpu_access(1'b0, MEM_HI, '0, 1'b0, rd, missed, faulted);
    compare_word("high memory read data", rd, initial_word(MEM_HI));
    expect_counts(mem0 + 1, dma0 + 3);
    finish_test("dma_region", errs);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    errors                    = 0;
    tests_run                 = 0;
    RST                       = 1'b1;
    cache_precycle_addr       = '0;
    cache_datao               = '0;
    cache_precycle_we         = 1'b0;
    cache_precycle_enable     = 1'b0;
    cache_precycle_force_miss = 1'b0;
    VMEM_ACT                  = 1'b0;
    WE_TLB                    = 1'b0;
    repeat (8) @(posedge CPU_CLK);
    @(negedge CPU_CLK);
    RST = 1'b0;
    read_miss_then_hit();
    write_through_hit();
    conflict_eviction();
    forced_miss_refetch();
    page_translation();
    dma_region_split();
    $display("Tests %0d, errors %0d, memory accesses %0d, DMA accesses %0d",
             tests_run, errors, mem_count, dma_count);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/snowball_pkg.sv
verilog/cache_array.sv
verilog/tlb_unit.sv
verilog/cache_ctrl.sv
verilog/bus_master.sv
verilog/snowball_cache.sv
tests/snowball_mem_model.sv
tests/tb_snowball_cache.sv

//--- Makefile
TOP = tb_snowball_cache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
